// File: verif/xbar_testdata.txt
# in0..in3 as valid ctrl data, out0..out3 as wr ctrl data, then the in_full mask
# outputs are the values after the rising edge that samples the inputs on the same line
0 00 0000  0 00 0000  0 00 0000  0 00 0000  0 00 0000  0 00 0000  0 00 0000  0 00 0000  0
0 00 0000  0 00 0000  1 11 A201  0 00 0000  0 00 0000  0 00 0000  0 00 0000  0 00 0000  0
0 00 0000  0 00 0000  0 00 0000  0 00 0000  0 00 0000  1 11 A201  0 00 0000  0 00 0000  0
1 23 B003  0 00 0000  0 00 0000  0 00 0000  0 00 0000  0 11 A201  0 00 0000  0 00 0000  0
0 00 0000  0 00 0000  0 00 0000  1 30 C300  0 00 0000  0 11 A201  0 00 0000  1 23 B003  0
0 00 0000  1 42 D102  0 00 0000  0 00 0000  1 30 C300  0 11 A201  0 00 0000  0 23 B003  0
0 00 0000  0 00 0000  0 00 0000  0 00 0000  0 30 C300  0 11 A201  1 42 D102  0 23 B003  0
1 52 1102  1 60 2200  1 73 3303  1 81 4401  0 30 C300  0 11 A201  0 42 D102  0 23 B003  0
0 00 0000  0 00 0000  0 00 0000  0 00 0000  1 60 2200  1 81 4401  1 52 1102  1 73 3303  0
0 00 0000  1 93 5513  1 A3 6623  0 00 0000  0 60 2200  0 81 4401  0 52 1102  0 73 3303  0
0 00 0000  0 00 0000  0 00 0000  0 00 0000  0 60 2200  0 81 4401  0 52 1102  1 93 5513  0
0 00 0000  0 00 0000  0 00 0000  0 00 0000  0 60 2200  0 81 4401  0 52 1102  1 A3 6623  0
0 00 0000  0 00 0000  0 00 0000  1 B0 7030  0 60 2200  0 81 4401  0 52 1102  0 A3 6623  0
0 00 0000  0 00 0000  0 00 0000  1 C2 7132  1 B0 7030  0 81 4401  0 52 1102  0 A3 6623  0
0 00 0000  0 00 0000  0 00 0000  1 D1 7231  0 B0 7030  0 81 4401  1 C2 7132  0 A3 6623  0
0 00 0000  0 00 0000  0 00 0000  0 00 0000  0 B0 7030  1 D1 7231  0 C2 7132  0 A3 6623  0
0 00 0000  0 00 0000  0 00 0000  0 00 0000  0 B0 7030  0 D1 7231  0 C2 7132  0 A3 6623  0
1 F0 0A00  1 E0 1A00  0 00 0000  0 00 0000  0 B0 7030  0 D1 7231  0 C2 7132  0 A3 6623  0
1 F0 0A01  1 E0 1A01  0 00 0000  0 00 0000  1 F0 0A00  0 D1 7231  0 C2 7132  0 A3 6623  0
1 F0 0A02  1 E0 1A02  0 00 0000  0 00 0000  1 F0 0A01  0 D1 7231  0 C2 7132  0 A3 6623  0
1 F0 0A03  1 E0 1A03  0 00 0000  0 00 0000  1 F0 0A02  0 D1 7231  0 C2 7132  0 A3 6623  0
1 F0 0A04  1 E0 1A04  0 00 0000  0 00 0000  1 F0 0A03  0 D1 7231  0 C2 7132  0 A3 6623  0
1 F0 0A05  1 E0 1A05  0 00 0000  0 00 0000  1 F0 0A04  0 D1 7231  0 C2 7132  0 A3 6623  0
1 F0 0A06  1 E0 1A06  0 00 0000  0 00 0000  1 F0 0A05  0 D1 7231  0 C2 7132  0 A3 6623  0
1 F0 0A07  1 E0 1A07  0 00 0000  0 00 0000  1 F0 0A06  0 D1 7231  0 C2 7132  0 A3 6623  2
1 F0 0A08  0 00 0000  0 00 0000  0 00 0000  1 F0 0A07  0 D1 7231  0 C2 7132  0 A3 6623  2
0 00 0000  0 00 0000  0 00 0000  0 00 0000  1 F0 0A08  0 D1 7231  0 C2 7132  0 A3 6623  2
0 00 0000  0 00 0000  0 00 0000  0 00 0000  1 E0 1A00  0 D1 7231  0 C2 7132  0 A3 6623  0
0 00 0000  0 00 0000  0 00 0000  0 00 0000  1 E0 1A01  0 D1 7231  0 C2 7132  0 A3 6623  0
0 00 0000  0 00 0000  0 00 0000  0 00 0000  1 E0 1A02  0 D1 7231  0 C2 7132  0 A3 6623  0
0 00 0000  0 00 0000  0 00 0000  0 00 0000  1 E0 1A03  0 D1 7231  0 C2 7132  0 A3 6623  0
0 00 0000  0 00 0000  0 00 0000  0 00 0000  1 E0 1A04  0 D1 7231  0 C2 7132  0 A3 6623  0
0 00 0000  0 00 0000  0 00 0000  0 00 0000  1 E0 1A05  0 D1 7231  0 C2 7132  0 A3 6623  0
0 00 0000  0 00 0000  0 00 0000  0 00 0000  1 E0 1A06  0 D1 7231  0 C2 7132  0 A3 6623  0
0 00 0000  0 00 0000  0 00 0000  0 00 0000  1 E0 1A07  0 D1 7231  0 C2 7132  0 A3 6623  0
0 00 0000  0 00 0000  0 00 0000  0 00 0000  0 E0 1A07  0 D1 7231  0 C2 7132  0 A3 6623  0

// File: xbar.f
+incdir+include
logic/cell_pkg.sv
logic/sched_pkg.sv
logic/queue_if.sv
logic/ingress_queue.sv
logic/port_scheduler.sv
logic/crossbar_switch.sv
logic/xbar_top.sv
verif/xbar_props.sv
verif/xbar_tb.sv

// File: Bender.yml
package:
  name: xbar

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/cell_pkg.sv
      - logic/sched_pkg.sv
      - logic/queue_if.sv
      - logic/ingress_queue.sv
      - logic/port_scheduler.sv
      - logic/crossbar_switch.sv
      - logic/xbar_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/xbar_props.sv
      - verif/xbar_tb.sv

// File: verif/xbar_tb.sv
`include "xbar_consts.svh"

module xbar_tb
	import cell_pkg::*, sched_pkg::*;
();

	// per line 3 fields for each input and output plus the full mask
	localparam int NUM_FIELDS    = 6 * `XBAR_PORTS + 1;
	localparam int FULL_FIELD    = 6 * `XBAR_PORTS;
	localparam int RESET_TIMEOUT = 20;
	localparam int MAX_LINES     = 500;

	logic       clk;
	logic       rst;
	port_mask_t in_valid;
	cell_ctrl_t in_ctrl [`XBAR_PORTS];
	cell_data_t in_data [`XBAR_PORTS];
	port_mask_t in_full;
	port_mask_t out_wr;
	cell_ctrl_t out_ctrl [`XBAR_PORTS];
	cell_data_t out_data [`XBAR_PORTS];

	logic [31:0] field [NUM_FIELDS];
	int          error_count;
	int          row_count;

	xbar_top UUT (
		.clk       (clk),
		.rst       (rst),
		.in_valid0 (in_valid[0]),
		.in_ctrl0  (in_ctrl[0]),
		.in_data0  (in_data[0]),
		.in_valid1 (in_valid[1]),
		.in_ctrl1  (in_ctrl[1]),
		.in_data1  (in_data[1]),
		.in_valid2 (in_valid[2]),
		.in_ctrl2  (in_ctrl[2]),
		.in_data2  (in_data[2]),
		.in_valid3 (in_valid[3]),
		.in_ctrl3  (in_ctrl[3]),
		.in_data3  (in_data[3]),
		.in_full0  (in_full[0]),
		.in_full1  (in_full[1]),
		.in_full2  (in_full[2]),
		.in_full3  (in_full[3]),
		.out_wr0   (out_wr[0]),
		.out_ctrl0 (out_ctrl[0]),
		.out_data0 (out_data[0]),
		.out_wr1   (out_wr[1]),
		.out_ctrl1 (out_ctrl[1]),
		.out_data1 (out_data[1]),
		.out_wr2   (out_wr[2]),
		.out_ctrl2 (out_ctrl[2]),
		.out_data2 (out_data[2]),
		.out_wr3   (out_wr[3]),
		.out_ctrl3 (out_ctrl[3]),
		.out_data3 (out_data[3])
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// reset held for three cycles and released on a falling edge
	initial begin
		rst = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED at time %0t: %s expected %h, got %h",
				$time, what, expected, actual);
			abort_run("output differs from the data file");
		end
	endtask

	// hex tokens into field[] up to any '#'
	task automatic split_fields(input string line, output int count);
		int  start;
		byte ch;
		count = 0;
		start = -1;
		for (int i = 0; i <= line.len(); i++) begin
			ch = (i < line.len()) ? line[i] : 8'h20;
			if (ch == "#") begin
				ch = 8'h20;
				i  = line.len();
			end
			if (ch == " " || ch == "\t" || ch == "\n" || ch == "\r") begin
				if (start >= 0) begin
					if (count < NUM_FIELDS) begin
						field[count] = line.substr(start, i - 1).atohex();
					end
					count++;
					start = -1;
				end
			end else if (start < 0) begin
				start = i;
			end
		end
	endtask

	task automatic apply_inputs();
		for (int p = 0; p < `XBAR_PORTS; p++) begin
			in_valid[p] = field[3*p][0];
			in_ctrl[p]  = cell_ctrl_t'(field[3*p+1]);
			in_data[p]  = cell_data_t'(field[3*p+2]);
		end
	endtask

	task automatic check_outputs();
		for (int p = 0; p < `XBAR_PORTS; p++) begin
			int base;
			base = 3 * `XBAR_PORTS + 3 * p;
			check_value(32'(out_wr[p]), field[base],
				$sformatf("row %0d out_wr%0d", row_count, p));
			check_value(32'(out_ctrl[p]), field[base+1],
				$sformatf("row %0d out_ctrl%0d", row_count, p));
			check_value(32'(out_data[p]), field[base+2],
				$sformatf("row %0d out_data%0d", row_count, p));
		end
		check_value(32'(in_full), field[FULL_FIELD], $sformatf("row %0d in_full", row_count));
	endtask

	initial begin
		int    fd;
		int    n;
		int    waited;
		int    lines;
		string line;

		error_count = 0;
		row_count   = 0;
		in_valid    = '0;
		for (int p = 0; p < `XBAR_PORTS; p++) begin
			in_ctrl[p] = '0;
			in_data[p] = '0;
		end

		waited = 0;
		while (rst !== 1'b1) begin
			if (waited >= RESET_TIMEOUT) begin
				abort_run("timed out waiting for reset to be released");
			end
			@(negedge clk);
			waited++;
		end

		fd = $fopen("verif/xbar_testdata.txt", "r");
		if (fd == 0) begin
			abort_run("could not open verif/xbar_testdata.txt");
		end

		// one line per cycle with outputs checked on the next falling edge
		lines = 0;
		while (!$feof(fd)) begin
			if (lines >= MAX_LINES) begin
				abort_run("timed out before reaching the end of the data file");
			end
			lines++;
			line = "";
			n = $fgets(line, fd);
			if (n > 0) begin
				split_fields(line, n);
				if (n != 0 && n != NUM_FIELDS) begin
					abort_run($sformatf("data file line %0d has %0d fields", lines, n));
				end
				if (n == NUM_FIELDS) begin
					apply_inputs();
					@(posedge clk);
					@(negedge clk);
					check_outputs();
					row_count++;
				end
			end
		end
		$fclose(fd);

		if (row_count == 0) begin
			abort_run("the data file held no test vectors");
		end
		if (error_count == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			abort_run("mismatches were found");
		end
	end

endmodule

// File: verif/xbar_props.sv
`include "xbar_consts.svh"

module xbar_props
	import cell_pkg::*, sched_pkg::*;
(
	input logic       clk,
	input logic       rst,
	input grant_t     grants [`XBAR_PORTS],
	input port_mask_t out_wr,
	input cell_ctrl_t out_ctrl [`XBAR_PORTS],
	input cell_data_t out_data [`XBAR_PORTS]
);

	// outputs fed by each input this cycle
	port_mask_t served [`XBAR_PORTS];

	always_comb begin
		for (int i = 0; i < `XBAR_PORTS; i++) begin
			for (int o = 0; o < `XBAR_PORTS; o++) begin
				served[i][o] = grants[o].valid && (grants[o].src == port_idx_t'(i));
			end
		end
	end

	for (genvar g = 0; g < `XBAR_PORTS; g++) begin : g_chk
		// a head cell leaves on one output at most
		a_one_grant: assert property (@(posedge clk) disable iff (!rst)
			$onehot0(served[g]))
			else $error("input %0d granted to several outputs", g);

		// a strobed cell must be addressed to this output
		a_wr_routed: assert property (@(posedge clk) disable iff (!rst)
			out_wr[g] |-> (ctrl_dest(out_ctrl[g]) == dest_t'(g)))
			else $error("out_wr%0d strobed a cell addressed elsewhere", g);

		a_idle_in_reset: assert property (@(posedge clk)
			!rst |-> (!out_wr[g] && out_ctrl[g] == '0 && out_data[g] == '0))
			else $error("output %0d not idle during reset", g);
	end

endmodule

bind crossbar_switch xbar_props u_props (
	.clk      (clk),
	.rst      (rst),
	.grants   (grants),
	.out_wr   (out_wr),
	.out_ctrl (out_ctrl),
	.out_data (out_data)
);

// File: logic/xbar_top.sv
`include "xbar_consts.svh"

module xbar_top
	import cell_pkg::*, sched_pkg::*;
(
	input  logic       clk,
	input  logic       rst,

	input  logic       in_valid0,
	input  cell_ctrl_t in_ctrl0,
	input  cell_data_t in_data0,
	input  logic       in_valid1,
	input  cell_ctrl_t in_ctrl1,
	input  cell_data_t in_data1,
	input  logic       in_valid2,
	input  cell_ctrl_t in_ctrl2,
	input  cell_data_t in_data2,
	input  logic       in_valid3,
	input  cell_ctrl_t in_ctrl3,
	input  cell_data_t in_data3,

	output logic       in_full0,
	output logic       in_full1,
	output logic       in_full2,
	output logic       in_full3,

	output logic       out_wr0,
	output cell_ctrl_t out_ctrl0,
	output cell_data_t out_data0,
	output logic       out_wr1,
	output cell_ctrl_t out_ctrl1,
	output cell_data_t out_data1,
	output logic       out_wr2,
	output cell_ctrl_t out_ctrl2,
	output cell_data_t out_data2,
	output logic       out_wr3,
	output cell_ctrl_t out_ctrl3,
	output cell_data_t out_data3
);

	port_mask_t in_valid;
	port_mask_t in_full;
	cell_ctrl_t in_ctrl [`XBAR_PORTS];
	cell_data_t in_data [`XBAR_PORTS];
	grant_t     grants [`XBAR_PORTS];
	port_mask_t out_wr;
	cell_ctrl_t out_ctrl [`XBAR_PORTS];
	cell_data_t out_data [`XBAR_PORTS];

	queue_if q ();

	// numbered ports onto arrays
	assign in_valid = {in_valid3, in_valid2, in_valid1, in_valid0};
	assign in_ctrl  = '{in_ctrl0, in_ctrl1, in_ctrl2, in_ctrl3};
	assign in_data  = '{in_data0, in_data1, in_data2, in_data3};

	assign {in_full3, in_full2, in_full1, in_full0} = in_full;
	assign {out_wr3, out_wr2, out_wr1, out_wr0}     = out_wr;

	assign out_ctrl0 = out_ctrl[0];
	assign out_data0 = out_data[0];
	assign out_ctrl1 = out_ctrl[1];
	assign out_data1 = out_data[1];
	assign out_ctrl2 = out_ctrl[2];
	assign out_data2 = out_data[2];
	assign out_ctrl3 = out_ctrl[3];
	assign out_data3 = out_data[3];

	for (genvar i = 0; i < `XBAR_PORTS; i++) begin : g_queue
		ingress_queue u_queue (
			.clk       (clk),
			.rst       (rst),
			.wr_en     (in_valid[i]),
			.din_ctrl  (in_ctrl[i]),
			.din_data  (in_data[i]),
			.rd_en     (q.rd_en[i]),
			.dout_ctrl (q.ctrl[i]),
			.dout_data (q.data[i]),
			.empty     (q.empty[i]),
			.full      (in_full[i])
		);
	end

	port_scheduler u_sched (
		.q      (q.sched),
		.grants (grants)
	);

	crossbar_switch u_switch (
		.clk      (clk),
		.rst      (rst),
		.q        (q.switch),
		.grants   (grants),
		.out_wr   (out_wr),
		.out_ctrl (out_ctrl),
		.out_data (out_data)
	);

endmodule

// File: logic/crossbar_switch.sv
`include "xbar_consts.svh"

module crossbar_switch
	import cell_pkg::*, sched_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	queue_if.switch    q,
	input  grant_t     grants [`XBAR_PORTS],
	output port_mask_t out_wr,
	output cell_ctrl_t out_ctrl [`XBAR_PORTS],
	output cell_data_t out_data [`XBAR_PORTS]
);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			out_wr <= '0;
			for (int o = 0; o < `XBAR_PORTS; o++) begin
				out_ctrl[o] <= '0;
				out_data[o] <= '0;
			end
		end else begin
			for (int o = 0; o < `XBAR_PORTS; o++) begin
				// strobe lasts one cycle per granted cell
				out_wr[o] <= grants[o].valid;
				if (grants[o].valid) begin
					out_ctrl[o] <= q.ctrl[grants[o].src];
					out_data[o] <= q.data[grants[o].src];
				end
			end
		end
	end

	// idle outputs hold the last cell they sent

endmodule

// File: logic/port_scheduler.sv
`include "xbar_consts.svh"

module port_scheduler
	import cell_pkg::*, sched_pkg::*;
(
	queue_if.sched q,
	output grant_t grants [`XBAR_PORTS]
);

	// outputs already claimed this cycle
	port_mask_t taken;
	port_mask_t rd_mask;
	dest_t      dest [`XBAR_PORTS];

	always_comb begin
		for (int i = 0; i < `XBAR_PORTS; i++) begin
			dest[i] = ctrl_dest(q.ctrl[i]);
		end
	end

	// lower input index wins and losers keep their head for next cycle
	always_comb begin
		taken   = '0;
		rd_mask = '0;
		for (int o = 0; o < `XBAR_PORTS; o++) begin
			grants[o].valid = 1'b0;
			grants[o].src   = '0;
		end
		for (int i = 0; i < `XBAR_PORTS; i++) begin
			if (!q.empty[i] && !taken[dest[i]]) begin
				taken[dest[i]]        = 1'b1;
				rd_mask[i]            = 1'b1;
				grants[dest[i]].valid = 1'b1;
				grants[dest[i]].src   = port_idx_t'(i);
			end
		end
	end

	// only granted heads are popped
	assign q.rd_en = rd_mask;

endmodule

// File: logic/ingress_queue.sv
`include "xbar_consts.svh"

module ingress_queue
	import cell_pkg::*;
#(
	parameter int DEPTH = `XBAR_QUEUE_DEPTH
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       wr_en,
	input  cell_ctrl_t din_ctrl,
	input  cell_data_t din_data,
	input  logic       rd_en,
	output cell_ctrl_t dout_ctrl,
	output cell_data_t dout_data,
	output logic       empty,
	output logic       full
);

	localparam int AW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	cell_ctrl_t ctrl_mem [DEPTH];
	cell_data_t data_mem [DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          push;
	logic          pop;

	assign empty = (count == '0);
	assign full  = (count == CW'(DEPTH));

	// writes into a full queue and reads from an empty one are dropped
	assign push = wr_en && !full;
	assign pop  = rd_en && !empty;

	// head falls through straight from the read pointer
	assign dout_ctrl = ctrl_mem[rd_ptr];
	assign dout_data = data_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			ctrl_mem[wr_ptr] <= din_ctrl;
			data_mem[wr_ptr] <= din_data;
		end
	end

	// pointers wrap on their own since depth is a power of two
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: logic/queue_if.sv
`include "xbar_consts.svh"

interface queue_if
	import cell_pkg::*, sched_pkg::*;
();

	// head cell of each ingress queue
	cell_data_t data [`XBAR_PORTS];
	cell_ctrl_t ctrl [`XBAR_PORTS];

	port_mask_t empty;

	// pop strobes back to the queues
	port_mask_t rd_en;

	modport queue (
		output data,
		output ctrl,
		output empty,
		input  rd_en
	);

	modport sched (
		input  empty,
		input  ctrl,
		output rd_en
	);

	modport switch (
		input data,
		input ctrl
	);

endinterface

// File: logic/sched_pkg.sv
`include "xbar_consts.svh"

package sched_pkg;

	// input port number, same width as a destination
	typedef logic [`XBAR_DEST_W-1:0] port_idx_t;

	// one bit per port
	typedef logic [`XBAR_PORTS-1:0] port_mask_t;

	// per output grant flag and winning input
	typedef struct packed {
		logic      valid;
		port_idx_t src;
	} grant_t;

endpackage

// File: logic/cell_pkg.sv
`include "xbar_consts.svh"

package cell_pkg;

	// payload carried through the switch untouched
	typedef logic [`XBAR_DATA_W-1:0] cell_data_t;

	// control word travelling with the payload
	typedef logic [`XBAR_CTRL_W-1:0] cell_ctrl_t;

	// output port addressed by a cell
	typedef logic [`XBAR_DEST_W-1:0] dest_t;

	// destination decode from the control word
	function automatic dest_t ctrl_dest(cell_ctrl_t ctrl);
		return ctrl[`XBAR_DEST_W-1:0];
	endfunction

endpackage

// File: include/xbar_consts.svh
`ifndef XBAR_CONSTS_SVH
`define XBAR_CONSTS_SVH

// ports on each side of the crossbar
`define XBAR_PORTS 4

// cell payload and control word
`define XBAR_DATA_W 16
`define XBAR_CTRL_W 8

// destination sits in the low bits of the control word
`define XBAR_DEST_W 2

// cells per ingress queue as a power of two
`define XBAR_QUEUE_DEPTH 8

`endif
